// File: design/fcmp_defines.svh
`ifndef FCMP_DEFINES_SVH
`define FCMP_DEFINES_SVH

////////////////////////////////////////
// single precision format
////////////////////////////////////////

`define FLEN 32  // operand width
`define NE   8   // exponent field
`define NF   23  // stored fraction, mantissa is NF+1 with implicit bit

// integer result width, one compare bit in bit 0
`define XLEN 32

// risc-v canonical quiet nan
`define CANONNAN 32'h7fc0_0000

`endif

// File: design/fcmpPkg.sv
package fcmpPkg;

  ////////////////////////////////////////
  // compare unit operation codes
  ////////////////////////////////////////

  // bit 0 set on max and the less-than forms,
  // bit 1 set on min and the equal forms
  typedef enum logic [2:0] {
    opLt  = 3'b001,  // flt, fltq with zfa
    opEq  = 3'b010,  // feq
    opLe  = 3'b011,  // fle, fleq with zfa
    opMax = 3'b101,  // fmax, fmaxm with zfa
    opMin = 3'b110   // fmin, fminm with zfa
  } fcmpOp;

  // 100, 000 and 111 are unused, the
  // compare stage answers them with zeros

endpackage

// File: design/fpClassify.sv
`timescale 1ns/1ps
`include "fcmp_defines.svh"

module fpClassify (
  input  logic                clk,
  input  logic                rstN,
  input  logic                inValid,            // one-cycle strobe, no back-pressure
  input  logic [`FLEN-1:0]    x,
  input  logic [`FLEN-1:0]    y,
  input  fcmpPkg::fcmpOp      op,
  input  logic                zfa,                // fminm/fmaxm/fltq/fleq
  output logic                s1Valid,
  output fcmpPkg::fcmpOp      s1Op,
  output logic                s1Zfa,
  output logic [`FLEN-1:0]    s1X, s1Y,           // raw operands for eq and min/max
  output logic                s1Xs, s1Ys,         // signs
  output logic [`NE-1:0]      s1Xe, s1Ye,         // biased exponents
  output logic [`NF:0]        s1Xm, s1Ym,         // mantissa with implicit bit
  output logic                s1XZero, s1YZero,
  output logic                s1XNaN, s1YNaN,
  output logic                s1XSNaN, s1YSNaN
);

  ////////////////////////////////////////
  // field helpers, same code for x and y
  ////////////////////////////////////////

  function automatic logic [`NE-1:0] expOf(input logic [`FLEN-1:0] v);
    return v[`FLEN-2:`NF];
  endfunction

  // implicit bit only for normals and inf/nan
  function automatic logic [`NF:0] mantOf(input logic [`FLEN-1:0] v);
    return {|v[`FLEN-2:`NF], v[`NF-1:0]};
  endfunction

  function automatic logic isZero(input logic [`FLEN-1:0] v);
    return ~|v[`FLEN-2:0];  // exp and frac all zero, either sign
  endfunction

  function automatic logic isNaN(input logic [`FLEN-1:0] v);
    return (&v[`FLEN-2:`NF]) & (|v[`NF-1:0]);
  endfunction

  // quiet bit is the top fraction bit
  function automatic logic isSNaN(input logic [`FLEN-1:0] v);
    return isNaN(v) & ~v[`NF-1];
  endfunction

  ////////////////////////////////////////
  // stage 1 registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;  // one pulse per accepted op
    end
  end

  // payload only moves on an accepted transaction
  always_ff @(posedge clk) begin
    if (inValid) begin
      s1Op    <= op;
      s1Zfa   <= zfa;
      s1X     <= x;
      s1Y     <= y;
      s1Xs    <= x[`FLEN-1];
      s1Ys    <= y[`FLEN-1];
      s1Xe    <= expOf(x);
      s1Ye    <= expOf(y);
      s1Xm    <= mantOf(x);
      s1Ym    <= mantOf(y);
      s1XZero <= isZero(x);
      s1YZero <= isZero(y);
      s1XNaN  <= isNaN(x);
      s1YNaN  <= isNaN(y);
      s1XSNaN <= isSNaN(x);
      s1YSNaN <= isSNaN(y);
    end
  end

endmodule

// File: design/fcmp.sv
`timescale 1ns/1ps
`include "fcmp_defines.svh"

module fcmp (
  input  logic                clk,
  input  logic                rstN,
  input  logic                s1Valid,
  input  fcmpPkg::fcmpOp      s1Op,
  input  logic                s1Zfa,
  input  logic [`FLEN-1:0]    s1X, s1Y,
  input  logic                s1Xs, s1Ys,
  input  logic [`NE-1:0]      s1Xe, s1Ye,
  input  logic [`NF:0]        s1Xm, s1Ym,
  input  logic                s1XZero, s1YZero,
  input  logic                s1XNaN, s1YNaN,
  input  logic                s1XSNaN, s1YSNaN,
  output logic                outValid,
  output logic [`FLEN-1:0]    cmpFpRes,   // fmin/fmax result
  output logic [`XLEN-1:0]    cmpIntRes,  // feq/flt/fle result in bit 0
  output logic                cmpNV       // invalid flag
);

  import fcmpPkg::*;

  logic               ltAbs;       // |x| < |y|
  logic               lt;          // signed x < y
  logic               eq;          // bit equal
  logic               bothZero;
  logic               eitherNaN;
  logic               eitherSNaN;
  logic [`FLEN-1:0]   minMaxRes;
  logic               nvNext;
  logic [`FLEN-1:0]   fpNext;
  logic               cmpBit;

  ////////////////////////////////////////
  // ordering
  ////////////////////////////////////////

  // exp then mantissa, compared as one unsigned number
  assign ltAbs = {s1Xe, s1Xm} < {s1Ye, s1Ym};
  assign eq    = (s1X == s1Y);

  // neg < pos, two negs flip the magnitude order
  // so -0 < +0 here; the compares patch that with bothZero
  assign lt = (s1Xs & ~s1Ys) |
              (s1Xs & s1Ys & ~ltAbs & ~eq) |
              (~s1Xs & ~s1Ys & ltAbs);

  assign bothZero   = s1XZero & s1YZero;
  assign eitherNaN  = s1XNaN | s1YNaN;
  assign eitherSNaN = s1XSNaN | s1YSNaN;

  ////////////////////////////////////////
  // min / max select
  ////////////////////////////////////////

  always_comb begin
    if (s1Zfa ? eitherNaN : (s1XNaN & s1YNaN)) begin
      minMaxRes = `CANONNAN;  // fminm/fmaxm on any nan, fmin/fmax on two
    end else if (s1XNaN) begin
      minMaxRes = s1Y;        // the number wins over a nan
    end else if (s1YNaN) begin
      minMaxRes = s1X;
    end else if (s1Op == opMax) begin
      minMaxRes = lt ? s1Y : s1X;
    end else begin
      minMaxRes = lt ? s1X : s1Y;
    end
  end

  ////////////////////////////////////////
  // per op result and flag
  ////////////////////////////////////////

  always_comb begin
    nvNext = 1'b0;
    fpNext = '0;
    cmpBit = 1'b0;
    case (s1Op)
      opMin, opMax: begin
        nvNext = eitherSNaN;  // quiet op
        fpNext = minMaxRes;
      end
      opEq: begin
        nvNext = eitherSNaN;
        cmpBit = (eq | bothZero) & ~eitherNaN;  // +0 == -0
      end
      opLt: begin
        // flt signals on any nan, fltq only on snan
        nvNext = s1Zfa ? eitherSNaN : eitherNaN;
        cmpBit = lt & ~bothZero & ~eitherNaN;
      end
      opLe: begin
        nvNext = s1Zfa ? eitherSNaN : eitherNaN;
        cmpBit = ((lt & ~bothZero) | eq | bothZero) & ~eitherNaN;
      end
      default: begin
        nvNext = 1'b0;  // unused codes give zeros
      end
    endcase
  end

  ////////////////////////////////////////
  // output registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid  <= 1'b0;
      cmpNV     <= 1'b0;
      cmpFpRes  <= '0;
      cmpIntRes <= '0;
    end else begin
      outValid <= s1Valid;
      if (s1Valid) begin
        cmpNV     <= nvNext;
        cmpFpRes  <= fpNext;
        cmpIntRes <= {{(`XLEN-1){1'b0}}, cmpBit};  // upper bits always zero
      end
    end
  end

endmodule

// File: design/fcmpUnit.sv
`timescale 1ns/1ps
`include "fcmp_defines.svh"

module fcmpUnit (
  input  logic                clk,
  input  logic                rstN,
  input  logic                inValid,    // accepted on every edge it is high
  input  logic [`FLEN-1:0]    x,
  input  logic [`FLEN-1:0]    y,
  input  fcmpPkg::fcmpOp      op,
  input  logic                zfa,
  output logic                outValid,   // two edges after inValid
  output logic [`FLEN-1:0]    cmpFpRes,
  output logic [`XLEN-1:0]    cmpIntRes,
  output logic                cmpNV
);

  import fcmpPkg::*;

  ////////////////////////////////////////
  // stage 1 to stage 2 bundle
  ////////////////////////////////////////

  logic               s1Valid;
  fcmpOp              s1Op;
  logic               s1Zfa;
  logic [`FLEN-1:0]   s1X, s1Y;
  logic               s1Xs, s1Ys;
  logic [`NE-1:0]     s1Xe, s1Ye;
  logic [`NF:0]       s1Xm, s1Ym;
  logic               s1XZero, s1YZero;
  logic               s1XNaN, s1YNaN;
  logic               s1XSNaN, s1YSNaN;

  // unpack and classify
  fpClassify u_classify (
    .clk, .rstN, .inValid, .x, .y, .op, .zfa,
    .s1Valid, .s1Op, .s1Zfa, .s1X, .s1Y,
    .s1Xs, .s1Ys, .s1Xe, .s1Ye, .s1Xm, .s1Ym,
    .s1XZero, .s1YZero, .s1XNaN, .s1YNaN, .s1XSNaN, .s1YSNaN
  );

  // order, select, register outputs
  fcmp u_cmp (
    .clk, .rstN,
    .s1Valid, .s1Op, .s1Zfa, .s1X, .s1Y,
    .s1Xs, .s1Ys, .s1Xe, .s1Ye, .s1Xm, .s1Ym,
    .s1XZero, .s1YZero, .s1XNaN, .s1YNaN, .s1XSNaN, .s1YSNaN,
    .outValid, .cmpFpRes, .cmpIntRes, .cmpNV
  );

endmodule

// File: verif/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  localparam int HalfPeriod = 20;  // 40 ns clock

  initial begin
    clk = 1'b0;  // first rising edge at 20 ns
    forever begin
      #HalfPeriod clk = ~clk;
    end
  end

endmodule

// File: verif/fcmp_properties.sv
`timescale 1ns/1ps
`include "fcmp_defines.svh"

module fcmpProperties (
  input logic               clk,
  input logic               rstN,
  input logic               inValid,
  input logic [`FLEN-1:0]   x,
  input logic [`FLEN-1:0]   y,
  input logic               outValid,
  input logic [`XLEN-1:0]   cmpIntRes
);

  int   failCount = 0;  // failed assertions so far
  logic anyNaN;         // either input operand is a nan

  assign anyNaN = ((&x[`FLEN-2:`NF]) & (|x[`NF-1:0])) |
                  ((&y[`FLEN-2:`NF]) & (|y[`NF-1:0]));

  ////////////////////////////////////////
  // pipeline timing
  ////////////////////////////////////////

  aLatency: assert property (@(posedge clk) disable iff (!rstN)
    inValid |-> ##2 outValid)
    else begin
      failCount++;
      $error("outValid did not follow inValid by two cycles");
    end

  aNoStray: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> $past(inValid, 2))
    else begin
      failCount++;
      $error("outValid without an accepted op two cycles before");
    end

  // quiet in reset and on the first two edges after it
  aResetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
    else begin
      failCount++;
      $error("outValid high during reset");
    end

  aAfterReset0: assert property (@(posedge clk) $rose(rstN) |-> !outValid)
    else begin
      failCount++;
      $error("outValid high on the first edge after reset");
    end

  aAfterReset1: assert property (@(posedge clk) $rose(rstN) |=> !outValid)
    else begin
      failCount++;
      $error("outValid high on the second edge after reset");
    end

  ////////////////////////////////////////
  // integer result rules
  ////////////////////////////////////////

  aUpperZero: assert property (@(posedge clk) cmpIntRes[`XLEN-1:1] == '0)
    else begin
      failCount++;
      $error("cmpIntRes has bits set above bit 0");
    end

  aNaNZero: assert property (@(posedge clk) disable iff (!rstN)
    outValid && $past(inValid && anyNaN, 2) |-> cmpIntRes == '0)
    else begin
      failCount++;
      $error("cmpIntRes nonzero for an unordered compare");
    end

endmodule

bind fcmpUnit fcmpProperties u_props (
  .clk(clk),
  .rstN(rstN),
  .inValid(inValid),
  .x(x),
  .y(y),
  .outValid(outValid),
  .cmpIntRes(cmpIntRes)
);

// File: verif/fcmpTb.sv
`timescale 1ns/1ps
`include "fcmp_defines.svh"

module fcmpTb;

  import fcmpPkg::*;

  // reset 5 + 42 single ops at ~4 cycles + 40 back-to-back + drain, ~220
  localparam int MaxCycles = 400;

  localparam logic [`FLEN-1:0] One   = 32'h3f80_0000;  // 1.0
  localparam logic [`FLEN-1:0] QNaN  = 32'h7fc0_0000;
  localparam logic [`FLEN-1:0] QNaN2 = 32'hffc1_2345;  // negative, with payload
  localparam logic [`FLEN-1:0] SNaN  = 32'h7f80_0001;  // quiet bit clear

  logic               clk;
  logic               rstN;
  logic               inValid;
  logic [`FLEN-1:0]   x;
  logic [`FLEN-1:0]   y;
  fcmpOp              op;
  logic               zfa;
  logic               outValid;
  logic [`FLEN-1:0]   cmpFpRes;
  logic [`XLEN-1:0]   cmpIntRes;
  logic               cmpNV;

  int     cycle = 0;
  int     txnId = 0;
  int     mismatches = 0;
  int     otherErrs = 0;
  integer seed;

  // expected results, oldest first
  logic [`FLEN-1:0]   expFpQ[$];
  logic [`XLEN-1:0]   expIntQ[$];
  logic               expNvQ[$];
  logic               expMinMaxQ[$];  // fp result is the one to check
  int                 expDueQ[$];     // cycle the result must show
  int                 expIdQ[$];

  tbClock u_clk (.clk(clk));

  fcmpUnit u_dut (
    .clk, .rstN, .inValid, .x, .y, .op, .zfa,
    .outValid, .cmpFpRes, .cmpIntRes, .cmpNV
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic isNan(input logic [`FLEN-1:0] v);
    return (v[`FLEN-2:`NF] == {`NE{1'b1}}) && (v[`NF-1:0] != '0);
  endfunction

  function automatic logic isSnan(input logic [`FLEN-1:0] v);
    return isNan(v) && !v[`NF-1];
  endfunction

  function automatic logic isZero(input logic [`FLEN-1:0] v);
    return v[`FLEN-2:0] == '0;
  endfunction

  // total order on the bit patterns, -0 below +0
  function automatic logic orderedLess(input logic [`FLEN-1:0] a, b);
    if (a[`FLEN-1] != b[`FLEN-1]) begin
      return a[`FLEN-1];
    end
    if (a[`FLEN-1]) begin
      return a[`FLEN-2:0] > b[`FLEN-2:0];  // negatives run backwards
    end
    return a[`FLEN-2:0] < b[`FLEN-2:0];
  endfunction

  task automatic refCompare(input logic [`FLEN-1:0] a, b, input fcmpOp o, input logic z,
                            output logic [`FLEN-1:0] fp, output logic [`XLEN-1:0] ib,
                            output logic nv);
    logic anyNan;
    logic anySnan;
    logic less;
    logic same;
    anyNan  = isNan(a) || isNan(b);
    anySnan = isSnan(a) || isSnan(b);
    less    = orderedLess(a, b) && !(isZero(a) && isZero(b));  // numeric less
    same    = (a == b) || (isZero(a) && isZero(b));
    fp      = '0;
    ib      = '0;
    case (o)
      opMin, opMax: begin
        nv = anySnan;
        if (z ? anyNan : (isNan(a) && isNan(b))) begin
          fp = `CANONNAN;
        end else if (isNan(a)) begin
          fp = b;
        end else if (isNan(b)) begin
          fp = a;
        end else if (o == opMin) begin
          fp = orderedLess(a, b) ? a : b;
        end else begin
          fp = orderedLess(a, b) ? b : a;
        end
      end
      opEq: begin
        nv    = anySnan;
        ib[0] = same && !anyNan;
      end
      opLt: begin
        nv    = z ? anySnan : anyNan;  // fltq quiet on qnan
        ib[0] = less && !anyNan;
      end
      default: begin
        nv    = z ? anySnan : anyNan;
        ib[0] = (less || same) && !anyNan;
      end
    endcase
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic checkFp(input string name, input int id,
                         input logic [`FLEN-1:0] got, input logic [`FLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s (txn %0d): got %h expected %h", name, id, got, exp);
      mismatches++;
    end
  endtask

  task automatic checkInt(input string name, input int id,
                          input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s (txn %0d): got %h expected %h", name, id, got, exp);
      mismatches++;
    end
  endtask

  task automatic checkFlag(input string name, input int id, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s (txn %0d): got %h expected %h", name, id, got, exp);
      mismatches++;
    end
  endtask

  ////////////////////////////////////////
  // drive, monitor, timeout
  ////////////////////////////////////////

  // sampled on the next edge, result two edges later
  task automatic issue(input logic [`FLEN-1:0] a, b, input fcmpOp o, input logic z);
    logic [`FLEN-1:0] fp;
    logic [`XLEN-1:0] ib;
    logic             nv;
    @(posedge clk);
    #2;
    inValid = 1'b1;
    x       = a;
    y       = b;
    op      = o;
    zfa     = z;
    refCompare(a, b, o, z, fp, ib, nv);
    expFpQ.push_back(fp);
    expIntQ.push_back(ib);
    expNvQ.push_back(nv);
    expMinMaxQ.push_back(o == opMin || o == opMax);
    expDueQ.push_back(cycle + 2);
    expIdQ.push_back(txnId);
    txnId++;
  endtask

  task automatic idle();
    @(posedge clk);
    #2;
    inValid = 1'b0;  // operands keep their last value
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (expFpQ.size() != 0 && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (expFpQ.size() != 0) begin
      $display("outValid missing: %0d result(s) still pending after %0d cycles",
               expFpQ.size(), limit);
      otherErrs++;
      expFpQ.delete();
      expIntQ.delete();
      expNvQ.delete();
      expMinMaxQ.delete();
      expDueQ.delete();
      expIdQ.delete();
    end
  endtask

  task automatic runOne(input logic [`FLEN-1:0] a, b, input fcmpOp o, input logic z);
    issue(a, b, o, z);
    idle();
    drain(6);
  endtask

  task automatic allOps(input logic [`FLEN-1:0] a, b, input logic z);
    runOne(a, b, opMin, z);
    runOne(a, b, opMax, z);
    runOne(a, b, opEq, z);
    runOne(a, b, opLt, z);
    runOne(a, b, opLe, z);
  endtask

  // outputs settle at the rising edge, read them mid cycle
  always @(negedge clk) begin
    if (rstN && outValid) begin
      if (expFpQ.size() == 0) begin
        $display("outValid high at cycle %0d with no transaction pending", cycle);
        otherErrs++;
      end else begin
        if (cycle != expDueQ[0]) begin
          $display("txn %0d finished at cycle %0d instead of cycle %0d",
                   expIdQ[0], cycle, expDueQ[0]);
          otherErrs++;
        end
        if (expMinMaxQ[0]) begin
          checkFp("cmpFpRes", expIdQ[0], cmpFpRes, expFpQ[0]);
        end else begin
          checkInt("cmpIntRes", expIdQ[0], cmpIntRes, expIntQ[0]);
        end
        checkFlag("cmpNV", expIdQ[0], cmpNV, expNvQ[0]);
        void'(expFpQ.pop_front());
        void'(expIntQ.pop_front());
        void'(expNvQ.pop_front());
        void'(expMinMaxQ.pop_front());
        void'(expDueQ.pop_front());
        void'(expIdQ.pop_front());
      end
    end
  end

  function automatic int totalErrors();
    return mismatches + otherErrs + u_dut.u_props.failCount;
  endfunction

  task automatic reportCounts();
    $display("errors: %0d mismatch, %0d protocol, %0d assertion",
             mismatches, otherErrs, u_dut.u_props.failCount);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MaxCycles) begin
      $display("timeout: run went past %0d cycles", MaxCycles);
      reportCounts();
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic testNormals();
    allOps(One, 32'h4000_0000, 1'b0);           // 1.0 vs 2.0
    allOps(32'hbfc0_0000, 32'h3f00_0000, 1'b0); // -1.5 vs 0.5
    allOps(32'hc040_0000, 32'hc000_0000, 1'b0); // -3.0 vs -2.0
    runOne(32'h4049_0fdb, 32'h4049_0fdb, opEq, 1'b0);
    runOne(32'h4049_0fdb, 32'h4049_0fdb, opLe, 1'b0);
  endtask

  task automatic testZeros();
    allOps(32'h8000_0000, 32'h0000_0000, 1'b0);  // -0 vs +0
    runOne(32'h7f80_0000, 32'h7f80_0000, opEq, 1'b0);
    runOne(32'hff80_0000, 32'hff80_0000, opLe, 1'b0);
    runOne(32'hff80_0000, 32'h7f80_0000, opLt, 1'b0);
  endtask

  task automatic testNanNoZfa();
    runOne(QNaN, One, opMin, 1'b0);    // number wins
    runOne(One, QNaN, opMax, 1'b0);
    runOne(QNaN, QNaN2, opMin, 1'b0);  // canonical nan
    runOne(QNaN, One, opEq, 1'b0);     // quiet
    runOne(One, QNaN, opLt, 1'b0);     // signals
    runOne(QNaN, One, opLe, 1'b0);
    allOps(SNaN, One, 1'b0);           // snan flags everywhere
  endtask

  task automatic testZfa();
    runOne(QNaN, One, opMin, 1'b1);
    runOne(One, QNaN2, opMax, 1'b1);
    runOne(QNaN, One, opLt, 1'b1);
    runOne(One, QNaN, opLe, 1'b1);
    runOne(SNaN, One, opLt, 1'b1);
    runOne(32'h8000_0000, 32'h0000_0000, opMin, 1'b1);
  endtask

  // specials mixed into the random stream
  function automatic logic [`FLEN-1:0] specialVal(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'h8000_0000;
      2:       return 32'h7f80_0000;
      3:       return 32'hff80_0000;
      4:       return QNaN;
      5:       return QNaN2;
      6:       return SNaN;
      7:       return 32'hff80_0001;  // negative snan
      8:       return One;
      9:       return 32'hbf80_0000;
      10:      return 32'h0000_0001;  // smallest subnormal
      default: return 32'h7f7f_ffff;  // largest normal
    endcase
  endfunction

  task automatic randOperand(output logic [`FLEN-1:0] v);
    int r;
    r = $random(seed);
    if (r[2:0] < 3'd3) begin
      v = specialVal($unsigned($random(seed)) % 12);
    end else begin
      v = $random(seed);
    end
  endtask

  task automatic testBackToBack();
    logic [`FLEN-1:0] a;
    logic [`FLEN-1:0] b;
    fcmpOp            o;
    int               k;
    int               r;
    for (int i = 0; i < 40; i++) begin
      randOperand(a);
      randOperand(b);
      k = $unsigned($random(seed)) % 5;
      r = $random(seed);
      case (k)
        0:       o = opMin;
        1:       o = opMax;
        2:       o = opEq;
        3:       o = opLt;
        default: o = opLe;
      endcase
      issue(a, b, o, r[0]);  // no gap between ops
    end
    idle();
    drain(8);
  endtask

  initial begin
    seed    = 35999;
    rstN    = 1'b0;
    inValid = 1'b0;
    x       = '0;
    y       = '0;
    op      = opEq;
    zfa     = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rstN = 1'b1;
    testNormals();
    testZeros();
    testNanNoZfa();
    testZfa();
    testBackToBack();
    reportCounts();
    if (totalErrors() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+design
design/fcmpPkg.sv
design/fpClassify.sv
design/fcmp.sv
design/fcmpUnit.sv
verif/tbClock.sv
verif/fcmp_properties.sv
verif/fcmpTb.sv

// File: Makefile
# verilator build and run of the fp compare unit

TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = fcmpTb
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
